//--- project.f
common/conv_pkg.sv
common/pe_feed_if.sv
design/stream_fifo.sv
conv_engine/conv_controller.sv
conv_engine/conv_row_pe.sv
conv_engine/row_sum_combiner.sv
design/conv_top.sv
verification/conv_tb.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - common/conv_pkg.sv
  - common/pe_feed_if.sv
  - design/stream_fifo.sv
  - conv_engine/conv_controller.sv
  - conv_engine/conv_row_pe.sv
  - conv_engine/row_sum_combiner.sv
  - design/conv_top.sv
  - target: test
    files:
      - verification/conv_tb.sv

//--- verification/conv_tb.sv
`timescale 1ns/100ps

module conv_tb;
    import conv_pkg::*;

    localparam int NUM_CASES = 6;
    localparam int MARGIN    = 8;

    typedef struct packed {
        dim_t       fm;
        logic [1:0] wt_pat;
        logic [1:0] px_pat;
        addr_t      wt_off;
        addr_t      ifm_off;
        addr_t      ofm_off;
    } case_t;

    logic  clk;
    logic  write_counter_rst;
    logic  start;
    logic  idle;
    dim_t  fm_dim;
    addr_t wt_offset;
    addr_t ifm_offset;
    addr_t ofm_offset;
    addr_t read_addr;
    len_t  read_len;
    logic  read_addr_valid;
    logic  read_addr_ready;
    data_t rdata;
    logic  rdata_valid;
    logic  rdata_ready;
    addr_t write_addr;
    len_t  write_len;
    logic  write_addr_valid;
    logic  write_addr_ready;
    acc_t  write_data;
    logic  write_data_valid;
    logic  write_data_ready;
    logic  resp_valid;
    logic  resp_ready;

    case_t       cases [NUM_CASES];
    data_t       wt_mem [WT_DIM*WT_DIM];
    data_t       px_mem [MAX_FM_DIM*MAX_FM_DIM];
    acc_t        golden [MAX_FM_DIM*MAX_FM_DIM];
    logic [31:0] lcg_state = 32'he303c0de;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          cur = 0;
    logic        model_on = 1'b0;

    // memory model bookkeeping
    int   rd_req_cnt = 0;
    int   rd_sel = 0;
    int   rd_idx = 0;
    int   rd_left = 0;
    int   wr_idx = 0;
    int   wa_cnt = 0;
    logic rd_taken = 1'b0;
    logic resp_sent = 1'b0;
    logic resp_done = 1'b0;

    conv_top conv_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input acc_t got, input acc_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // high three times out of four
    function automatic logic rand_ready();
        logic [31:0] r;
        r = lcg_next();
        return r[31:30] != 2'b00;
    endfunction

    function automatic data_t rand_word();
        logic [31:0] r;
        r = lcg_next();
        return data_t'(r[31:16]);
    endfunction

    // fills the memories and the zero-padded reference result
    task automatic load_case(input case_t tc);
        int     fm;
        int     k;
        int     pr;
        int     pc;
        longint acc;
        fm = int'(tc.fm);
        for (int m = 0; m < WT_DIM; m++) begin
            for (int n = 0; n < WT_DIM; n++) begin
                k = m * WT_DIM + n;
                case (tc.wt_pat)
                    2'd0: wt_mem[k] = (m == WT_DIM / 2 && n == WT_DIM / 2) ? data_t'(1) : '0;
                    2'd1: wt_mem[k] = data_t'(1);
                    2'd2: wt_mem[k] = data_t'(-(m * WT_DIM + n + 1));
                    default: wt_mem[k] = rand_word();
                endcase
            end
        end
        for (int r = 0; r < fm; r++) begin
            for (int col = 0; col < fm; col++) begin
                case (tc.px_pat)
                    2'd0: px_mem[r*fm+col] = data_t'(r * fm + col + 1);
                    2'd1: px_mem[r*fm+col] = rand_word();
                    default: px_mem[r*fm+col] = data_t'(-(r * 7 + col * 3 + 1));
                endcase
            end
        end
        for (int r = 0; r < fm; r++) begin
            for (int col = 0; col < fm; col++) begin
                acc = 0;
                for (int m = 0; m < WT_DIM; m++) begin
                    for (int n = 0; n < WT_DIM; n++) begin
                        pr = r + m - WT_DIM / 2;
                        pc = col + n - WT_DIM / 2;
                        if (pr >= 0 && pr < fm && pc >= 0 && pc < fm)
                            acc += longint'(wt_mem[m*WT_DIM+n]) * longint'(px_mem[pr*fm+pc]);
                    end
                end
                golden[r*fm+col] = acc_t'(acc);
            end
        end
        rd_req_cnt = 0;
        rd_left    = 0;
        rd_idx     = 0;
        wr_idx     = 0;
        wa_cnt     = 0;
        resp_sent  = 1'b0;
        resp_done  = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count > timeout_limit)
            report_error($sformatf("timeout after %0d cycles without finishing", cycle_count));
    end

    // memory side decides every handshake on the falling edge
    always @(negedge clk) begin : memory_model
        int fm_sq;
        fm_sq = int'(cases[cur].fm) * int'(cases[cur].fm);
        if (model_on) begin
            if (resp_valid) begin
                resp_valid = 1'b0;
                resp_done  = 1'b1;
                check_flag("idle", idle, 1'b1);
            end else if (wa_cnt == 1 && wr_idx == fm_sq && !resp_sent) begin
                check_flag("resp_ready", resp_ready, 1'b1);
                resp_valid = 1'b1;
                resp_sent  = 1'b1;
            end

            if (rd_taken) begin
                rdata_valid = 1'b0;
                rd_taken    = 1'b0;
            end
            if (!rdata_valid && rd_left > 0 && rand_ready()) begin
                rdata_valid = 1'b1;
                rdata       = (rd_sel == 0) ? wt_mem[rd_idx] : px_mem[rd_idx];
            end
            if (rdata_valid && rdata_ready) begin
                rd_idx++;
                rd_left--;
                rd_taken = 1'b1;
            end

            read_addr_ready = (rd_left == 0) && rand_ready();
            if (read_addr_valid && read_addr_ready) begin
                if (rd_req_cnt == 0) begin
                    check_addr("read_addr", read_addr, cases[cur].wt_off);
                    check_len("read_len", read_len, len_t'(WT_DIM * WT_DIM));
                end else if (rd_req_cnt == 1) begin
                    check_addr("read_addr", read_addr, cases[cur].ifm_off);
                    check_len("read_len", read_len, len_t'(fm_sq));
                end else begin
                    report_error("more than two read requests in one run");
                end
                rd_sel  = rd_req_cnt;
                rd_idx  = 0;
                rd_left = int'(read_len);
                rd_req_cnt++;
            end

            write_addr_ready = rand_ready();
            if (write_addr_valid && write_addr_ready) begin
                if (wa_cnt > 0)
                    report_error("second write request in one run");
                check_addr("write_addr", write_addr, cases[cur].ofm_off);
                check_len("write_len", write_len, len_t'(fm_sq));
                wa_cnt++;
            end

            write_data_ready = rand_ready();
            if (write_data_valid && write_data_ready) begin
                if (wr_idx >= fm_sq) begin
                    report_error("more write data words than fm_dim squared");
                end else begin
                    check_word("write_data", write_data, golden[wr_idx]);
                    wr_idx++;
                end
            end
        end
    end

    initial begin : stimulus
        int limit;
        int fm;
        write_counter_rst = 1'b1;
        start             = 1'b0;
        fm_dim            = '0;
        wt_offset         = '0;
        ifm_offset        = '0;
        ofm_offset        = '0;
        read_addr_ready   = 1'b0;
        rdata             = '0;
        rdata_valid       = 1'b0;
        write_addr_ready  = 1'b0;
        write_data_ready  = 1'b0;
        resp_valid        = 1'b0;

        // fm, weight pattern, pixel pattern, weight / input / output offsets
        cases[0] = '{4'd2, 2'd0, 2'd0, 32'h0000_0100, 32'h0000_1000, 32'h0000_8000};
        cases[1] = '{4'd3, 2'd1, 2'd0, 32'h0000_0200, 32'h0000_2000, 32'h0000_9000};
        cases[2] = '{4'd5, 2'd2, 2'd1, 32'h0001_0000, 32'h0002_0000, 32'h0003_0000};
        cases[3] = '{4'd8, 2'd3, 2'd1, 32'h8000_0040, 32'h8000_1000, 32'h9000_0000};
        cases[4] = '{4'd3, 2'd3, 2'd2, 32'h0000_0300, 32'h0000_3000, 32'h0000_a000};
        cases[5] = '{4'd8, 2'd1, 2'd2, 32'h00ff_0000, 32'h00fe_0000, 32'h00fd_0000};

        limit = 20;
        for (int i = 0; i < NUM_CASES; i++) begin
            fm = int'(cases[i].fm);
            limit += ((fm + 2) * (fm + 2) + WT_DIM * WT_DIM + fm * fm) * MARGIN + 64;
        end
        timeout_limit = limit;

        repeat (5) @(posedge clk);
        @(negedge clk);
        write_counter_rst = 1'b0;
        check_flag("idle", idle, 1'b1);
        check_flag("read_addr_valid", read_addr_valid, 1'b0);
        check_flag("write_addr_valid", write_addr_valid, 1'b0);
        check_flag("write_data_valid", write_data_valid, 1'b0);

        for (int i = 0; i < NUM_CASES; i++) begin
            @(posedge clk);
            cur = i;
            load_case(cases[i]);
            model_on = 1'b1;
            @(negedge clk);
            fm_dim     = cases[i].fm;
            wt_offset  = cases[i].wt_off;
            ifm_offset = cases[i].ifm_off;
            ofm_offset = cases[i].ofm_off;
            start      = 1'b1;
            @(negedge clk);
            start = 1'b0;
            wait (resp_done);
            if (rd_req_cnt != 2)
                report_error($sformatf("saw %0d read requests instead of two", rd_req_cnt));
            check_flag("write_data_valid", write_data_valid, 1'b0);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- design/conv_top.sv
`timescale 1ns/100ps

module conv_top (
    input  logic            clk,
    input  logic            write_counter_rst,
    input  logic            start,
    output logic            idle,
    input  conv_pkg::dim_t  fm_dim,
    input  conv_pkg::addr_t wt_offset,
    input  conv_pkg::addr_t ifm_offset,
    input  conv_pkg::addr_t ofm_offset,
    output conv_pkg::addr_t read_addr,
    output conv_pkg::len_t  read_len,
    output logic            read_addr_valid,
    input  logic            read_addr_ready,
    input  conv_pkg::data_t rdata,
    input  logic            rdata_valid,
    output logic            rdata_ready,
    output conv_pkg::addr_t write_addr,
    output conv_pkg::len_t  write_len,
    output logic            write_addr_valid,
    input  logic            write_addr_ready,
    output conv_pkg::acc_t  write_data,
    output logic            write_data_valid,
    input  logic            write_data_ready,
    input  logic            resp_valid,
    output logic            resp_ready
);
    import conv_pkg::*;

    pe_feed_if feed ();

    data_t             in_data;
    logic              in_valid;
    logic              in_ready;
    acc_t              pe_sum [WT_DIM];
    logic [WT_DIM-1:0] pe_sum_valid;
    acc_t              pe_head [WT_DIM];
    logic [WT_DIM-1:0] pe_head_valid;
    logic [WT_DIM-1:0] pe_head_ready;
    logic [WT_DIM-1:0] pe_almost_full;
    logic              pe_fifo_space;
    acc_t              out_data;
    logic              out_valid;
    logic              out_ready;
    logic              out_fire;

    // any PE FIFO near full stops the pixel stream
    assign pe_fifo_space = !(|pe_almost_full);

    conv_controller controller_inst (
        .clk(clk), .write_counter_rst(write_counter_rst),
        .start(start), .idle(idle), .fm_dim(fm_dim),
        .wt_offset(wt_offset), .ifm_offset(ifm_offset), .ofm_offset(ofm_offset),
        .read_addr(read_addr), .read_len(read_len),
        .read_addr_valid(read_addr_valid), .read_addr_ready(read_addr_ready),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .feed(feed.ctrl), .pe_fifo_space(pe_fifo_space), .out_fire(out_fire),
        .write_addr(write_addr), .write_len(write_len),
        .write_addr_valid(write_addr_valid), .write_addr_ready(write_addr_ready),
        .resp_valid(resp_valid), .resp_ready(resp_ready)
    );

    stream_fifo #(.payload_t(data_t), .DEPTH(IN_FIFO_DEPTH)) in_fifo_inst (
        .clk(clk), .write_counter_rst(write_counter_rst),
        .push_data(rdata), .push_valid(rdata_valid), .push_ready(rdata_ready),
        .pop_data(in_data), .pop_valid(in_valid), .pop_ready(in_ready),
        .almost_full()
    );

    for (genvar i = 0; i < WT_DIM; i++) begin : g_row
        conv_row_pe #(.ROW(i)) pe_inst (
            .clk(clk), .write_counter_rst(write_counter_rst), .fm_dim(fm_dim),
            .feed(feed.pe), .sum(pe_sum[i]), .sum_valid(pe_sum_valid[i])
        );

        stream_fifo #(.payload_t(acc_t), .DEPTH(PE_FIFO_DEPTH)) pe_fifo_inst (
            .clk(clk), .write_counter_rst(write_counter_rst),
            .push_data(pe_sum[i]), .push_valid(pe_sum_valid[i]), .push_ready(),
            .pop_data(pe_head[i]), .pop_valid(pe_head_valid[i]),
            .pop_ready(pe_head_ready[i]), .almost_full(pe_almost_full[i])
        );
    end

    row_sum_combiner combiner_inst (
        .clk(clk), .write_counter_rst(write_counter_rst),
        .part_data(pe_head), .part_valid(pe_head_valid), .part_ready(pe_head_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
        .out_fire(out_fire)
    );

    stream_fifo #(.payload_t(acc_t), .DEPTH(OUT_FIFO_DEPTH)) out_fifo_inst (
        .clk(clk), .write_counter_rst(write_counter_rst),
        .push_data(out_data), .push_valid(out_valid), .push_ready(out_ready),
        .pop_data(write_data), .pop_valid(write_data_valid),
        .pop_ready(write_data_ready), .almost_full()
    );

endmodule

//--- conv_engine/row_sum_combiner.sv
`timescale 1ns/100ps

module row_sum_combiner (
    input  logic                          clk,
    input  logic                          write_counter_rst,
    input  conv_pkg::acc_t                part_data [conv_pkg::WT_DIM],
    input  logic [conv_pkg::WT_DIM-1:0]   part_valid,
    output logic [conv_pkg::WT_DIM-1:0]   part_ready,
    output conv_pkg::acc_t                out_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic                          out_fire
);
    import conv_pkg::*;

    // join on every row partial
    assign out_valid  = &part_valid;
    assign out_fire   = out_valid && out_ready;
    assign part_ready = {WT_DIM{out_fire}};

    always_comb begin
        out_data = '0;
        for (int i = 0; i < WT_DIM; i++) begin
            out_data = out_data + part_data[i];
        end
    end

    // bottom kernel row closes every window last
    assert property (@(posedge clk) disable iff (write_counter_rst)
        part_valid[WT_DIM-1] |-> &part_valid);

endmodule

//--- conv_engine/conv_row_pe.sv
`timescale 1ns/100ps

module conv_row_pe #(
    parameter int ROW = 0
) (
    input  logic           clk,
    input  logic           write_counter_rst,
    input  conv_pkg::dim_t fm_dim,
    pe_feed_if.pe          feed,
    output conv_pkg::acc_t sum,
    output logic           sum_valid
);
    import conv_pkg::*;

    data_t weight [WT_DIM];
    data_t window [WT_DIM-1];
    dim_t  col;
    dim_t  pix_col;
    acc_t  dot;
    logic  emit;
    logic  last_pixel;
    logic  pixel_phase;
    int    out_row;

    // column of the pixel currently on the feed
    assign pix_col = feed.row_start ? '0 : col;
    assign out_row = int'(feed.pad_row) - ROW;

    assign emit = feed.pixel_valid && (out_row >= 0) && (out_row < int'(fm_dim)) &&
                  (pix_col >= WT_DIM - 1);
    assign last_pixel = feed.pixel_valid && (feed.pad_row == fm_dim + 1) &&
                        (pix_col == fm_dim + 1);

    // newest tap is the pixel on the feed
    always_comb begin
        dot = acc_t'(weight[WT_DIM-1]) * acc_t'(feed.pixel_data);
        for (int k = 0; k < WT_DIM - 1; k++) begin
            dot = dot + acc_t'(weight[k]) * acc_t'(window[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (feed.weight_valid && int'(feed.weight_row) == ROW)
            weight[feed.weight_col] <= feed.weight_data;
        if (feed.pixel_valid) begin
            for (int k = 0; k < WT_DIM - 2; k++) begin
                window[k] <= window[k+1];
            end
            window[WT_DIM-2] <= feed.pixel_data;
        end
        if (emit)
            sum <= dot;
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            col         <= '0;
            sum_valid   <= 1'b0;
            pixel_phase <= 1'b0;
        end else begin
            sum_valid <= emit;
            if (feed.pixel_valid)
                col <= pix_col + 1'b1;
            if (last_pixel)
                pixel_phase <= 1'b0;
            else if (feed.pixel_valid)
                pixel_phase <= 1'b1;
        end
    end

    // weights for the next map only after the padded stream ends
    assert property (@(posedge clk) disable iff (write_counter_rst)
        pixel_phase |-> !feed.weight_valid);

endmodule

//--- conv_engine/conv_controller.sv
`timescale 1ns/100ps

module conv_controller (
    input  logic            clk,
    input  logic            write_counter_rst,
    input  logic            start,
    output logic            idle,
    input  conv_pkg::dim_t  fm_dim,
    input  conv_pkg::addr_t wt_offset,
    input  conv_pkg::addr_t ifm_offset,
    input  conv_pkg::addr_t ofm_offset,
    output conv_pkg::addr_t read_addr,
    output conv_pkg::len_t  read_len,
    output logic            read_addr_valid,
    input  logic            read_addr_ready,
    input  conv_pkg::data_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    pe_feed_if.ctrl         feed,
    input  logic            pe_fifo_space,
    input  logic            out_fire,
    output conv_pkg::addr_t write_addr,
    output conv_pkg::len_t  write_len,
    output logic            write_addr_valid,
    input  logic            write_addr_ready,
    input  logic            resp_valid,
    output logic            resp_ready
);
    import conv_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_WT,
        S_LOAD_FM,
        S_DRAIN,
        S_WAIT_RESP
    } state_t;

    state_t  state;
    wt_idx_t m_cnt;
    wt_idx_t n_cnt;
    dim_t    x_cnt;
    dim_t    y_cnt;
    len_t    out_cnt;
    len_t    fm_sq;
    logic    halo;
    logic    in_fire;
    logic    last_wt;
    logic    last_x;
    logic    last_px;

    assign fm_sq = len_t'(fm_dim) * len_t'(fm_dim);

    // border of the padded map
    assign halo = (x_cnt == 0) || (y_cnt == 0) ||
                  (x_cnt == fm_dim + 1) || (y_cnt == fm_dim + 1);

    assign in_ready = (state == S_LOAD_WT) ||
                      (state == S_LOAD_FM && !halo && pe_fifo_space);
    assign in_fire  = in_valid && in_ready;
    assign last_wt  = (m_cnt == WT_DIM - 1) && (n_cnt == WT_DIM - 1);
    assign last_x   = (x_cnt == fm_dim + 1);
    assign last_px  = last_x && (y_cnt == fm_dim + 1);

    assign feed.weight_valid = (state == S_LOAD_WT) && in_fire;
    assign feed.weight_data  = in_data;
    assign feed.weight_row   = m_cnt;
    assign feed.weight_col   = n_cnt;
    // halo zeros go out without waiting on the input FIFO
    assign feed.pixel_valid  = (state == S_LOAD_FM) && pe_fifo_space && (halo || in_valid);
    assign feed.pixel_data   = halo ? '0 : in_data;
    assign feed.row_start    = (x_cnt == 0);
    assign feed.pad_row      = y_cnt;

    assign idle       = (state == S_IDLE);
    assign read_addr  = (state == S_LOAD_FM) ? ifm_offset : wt_offset;
    assign read_len   = (state == S_LOAD_FM) ? fm_sq : len_t'(WT_DIM * WT_DIM);
    assign write_addr = ofm_offset;
    assign write_len  = fm_sq;
    assign resp_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state            <= S_IDLE;
            m_cnt            <= '0;
            n_cnt            <= '0;
            x_cnt            <= '0;
            y_cnt            <= '0;
            out_cnt          <= '0;
            read_addr_valid  <= 1'b0;
            write_addr_valid <= 1'b0;
        end else begin
            if (read_addr_valid && read_addr_ready)
                read_addr_valid <= 1'b0;
            if (write_addr_valid && write_addr_ready)
                write_addr_valid <= 1'b0;
            if (out_fire)
                out_cnt <= out_cnt + 1'b1;

            case (state)
                S_IDLE: begin
                    if (start) begin
                        state           <= S_LOAD_WT;
                        read_addr_valid <= 1'b1;
                        m_cnt           <= '0;
                        n_cnt           <= '0;
                        x_cnt           <= '0;
                        y_cnt           <= '0;
                        out_cnt         <= '0;
                    end
                end
                S_LOAD_WT: begin
                    if (in_fire) begin
                        n_cnt <= n_cnt + 1'b1;
                        if (n_cnt == WT_DIM - 1) begin
                            n_cnt <= '0;
                            m_cnt <= m_cnt + 1'b1;
                        end
                        // request the feature map after the last weight
                        if (last_wt) begin
                            m_cnt           <= '0;
                            state           <= S_LOAD_FM;
                            read_addr_valid <= 1'b1;
                        end
                    end
                end
                S_LOAD_FM: begin
                    if (feed.pixel_valid) begin
                        x_cnt <= x_cnt + 1'b1;
                        if (last_x) begin
                            x_cnt <= '0;
                            y_cnt <= y_cnt + 1'b1;
                        end
                        if (last_px) begin
                            y_cnt <= '0;
                            state <= S_DRAIN;
                        end
                    end
                end
                S_DRAIN: begin
                    if (out_cnt == fm_sq) begin
                        write_addr_valid <= 1'b1;
                        state            <= S_WAIT_RESP;
                    end
                end
                S_WAIT_RESP: begin
                    // status word is not checked
                    if (resp_valid)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (write_counter_rst)
        read_addr_valid && !read_addr_ready |=>
            read_addr_valid && $stable(read_addr) && $stable(read_len));

    // outputs only while computing, never more than one map
    assert property (@(posedge clk) disable iff (write_counter_rst)
        out_fire |-> (state == S_LOAD_FM || state == S_DRAIN) && (out_cnt < fm_sq));

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     write_counter_rst,
    input  payload_t push_data,
    input  logic     push_valid,
    output logic     push_ready,
    output payload_t pop_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output logic     almost_full
);
    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push_fire;
    logic                       pop_fire;

    assign push_ready  = (count != DEPTH);
    assign pop_valid   = (count != 0);
    assign pop_data    = mem[rd_ptr];
    assign almost_full = (count >= DEPTH - 2);
    assign push_fire   = push_valid && push_ready;
    assign pop_fire    = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (push_fire)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop_fire)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a refused word must still be offered next cycle, or it is lost
    assert property (@(posedge clk) disable iff (write_counter_rst)
        push_valid && !push_ready |=> push_valid && $stable(push_data));

endmodule

//--- common/pe_feed_if.sv
`timescale 1ns/100ps

interface pe_feed_if;
    import conv_pkg::*;

    // weight broadcast, tagged with kernel position
    logic    weight_valid;
    data_t   weight_data;
    wt_idx_t weight_row;
    wt_idx_t weight_col;

    // padded pixel stream
    logic    pixel_valid;
    data_t   pixel_data;
    logic    row_start;
    dim_t    pad_row;

    modport ctrl (
        output weight_valid, weight_data, weight_row, weight_col,
        output pixel_valid, pixel_data, row_start, pad_row
    );

    modport pe (
        input weight_valid, weight_data, weight_row, weight_col,
        input pixel_valid, pixel_data, row_start, pad_row
    );

endinterface

//--- common/conv_pkg.sv
package conv_pkg;

    // kernel geometry
    localparam int WT_DIM     = 3;
    localparam int WT_IDX_W   = $clog2(WT_DIM);
    localparam int MAX_FM_DIM = 8;

    localparam int DATA_W = 16;
    localparam int ACC_W  = 40;
    localparam int ADDR_W = 32;
    localparam int LEN_W  = 16;
    localparam int DIM_W  = 4;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [LEN_W-1:0]         len_t;
    typedef logic [DIM_W-1:0]         dim_t;
    typedef logic [WT_IDX_W-1:0]      wt_idx_t;

    localparam int IN_FIFO_DEPTH  = 16;

    // first PE runs WT_DIM-1 output rows ahead of the last one,
    // so its FIFO holds those rows plus the almost-full margin
    localparam int PE_FIFO_DEPTH  = (WT_DIM - 1) * MAX_FM_DIM + 4;

    // whole output map fits, write side can stall freely
    localparam int OUT_FIFO_DEPTH = MAX_FM_DIM * MAX_FM_DIM;

endpackage
